/* src/gpif_pkg.sv */
package gpif_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and stream types
   ////////////////////////////////////////////////////////////////////////////

   // One GPIF bus beat or stream word
   typedef logic [31:0] gpif_word_t;

   // FX3 endpoint address on fifoadr
   typedef logic [1:0] gpif_addr_t;

   // Endpoint addresses as seen by the FX3 firmware
   localparam gpif_addr_t ADDR_DATA_TX = 2'd0;
   localparam gpif_addr_t ADDR_DATA_RX = 2'd1;

   // Bus master states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WAIT,
      ST_THINK,
      ST_READ,
      ST_READ_SINGLE,
      ST_READ_FLUSH,
      ST_WRITE,
      ST_WRITE_FLUSH
   } gpif_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // Pseudo-state counter and its timing points
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [2:0] gpif_count_t;

   // Last count of the settle wait, eight cycles in all
   localparam gpif_count_t SETTLE_COUNT = 3'd7;
   // Count where the resampled ready flag reflects the last single read
   localparam gpif_count_t SINGLE_RECHECK = 3'd5;
   // Flush starts, three cycles after pktend, two after a burst gap
   localparam gpif_count_t FLUSH_EOP_START = 3'd5;
   localparam gpif_count_t FLUSH_GAP_START = 3'd6;

endpackage

/* src/gpif_rd_if.sv */
`timescale 1ns/1ps

// Controller to read path signals
interface gpif_rd_if;

   // Controller side
   logic slrd;
   logic burst_active;
   logic single_active;
   logic rx_eop;

   // Read path side
   logic fx3_ready;
   logic fx3_wmark;
   logic slrd3_low;
   logic slrd3;
   logic nearly_full;

   modport ctrl (
      output slrd, burst_active, single_active, rx_eop,
      input  fx3_ready, fx3_wmark, slrd3_low, slrd3, nearly_full
   );

   modport path (
      input  slrd, burst_active, single_active, rx_eop,
      output fx3_ready, fx3_wmark, slrd3_low, slrd3, nearly_full
   );

endinterface

/* src/gpif_ep_if.sv */
`timescale 1ns/1ps

// Controller to endpoint selector signals
interface gpif_ep_if;
   import gpif_pkg::*;

   // Current address and the load strobe for the next one
   gpif_addr_t fifoadr;
   logic       addr_advance;

   // Selector side
   gpif_addr_t next_addr;
   logic       local_ready;
   logic       read_go;
   logic       write_go;

   modport ctrl (
      output fifoadr, addr_advance,
      input  next_addr, local_ready, read_go, write_go
   );

   modport sel (
      input  fifoadr, addr_advance,
      output next_addr, local_ready, read_go, write_go
   );

endinterface

/* src/gpif_sync_fifo.sv */
`timescale 1ns/1ps

// Single clock stream FIFO with programmable levels
module gpif_sync_fifo #(
   parameter int FIFO_DEPTH       = 64,
   parameter int NEARLY_FULL_MARK = 56,
   parameter int SPACE_MARK       = 16
) (
   input  logic                 gpif_clk,
   input  logic                 gpif_rst,
   input  gpif_pkg::gpif_word_t s_tdata,
   input  logic                 s_tlast,
   input  logic                 s_tvalid,
   output logic                 s_tready,
   output gpif_pkg::gpif_word_t m_tdata,
   output logic                 m_tlast,
   output logic                 m_tvalid,
   input  logic                 m_tready,
   output logic                 nearly_full,
   output logic                 has_space
);
   import gpif_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   typedef logic [PTR_W-1:0] fifo_ptr_t;
   typedef logic [CNT_W-1:0] fifo_count_t;

   gpif_word_t  data_mem [FIFO_DEPTH];
   logic        last_mem [FIFO_DEPTH];
   fifo_ptr_t   wr_ptr;
   fifo_ptr_t   rd_ptr;
   fifo_count_t count;
   logic        push;
   logic        pop;

   assign s_tready = (count != fifo_count_t'(FIFO_DEPTH));
   assign m_tvalid = (count != '0);
   assign push     = s_tvalid && s_tready;
   assign pop      = m_tvalid && m_tready;

   // Head of queue, read straight from storage
   assign m_tdata = data_mem[rd_ptr];
   assign m_tlast = last_mem[rd_ptr];

   // Levels from occupancy
   assign nearly_full = (count >= fifo_count_t'(NEARLY_FULL_MARK));
   assign has_space   = (count <= fifo_count_t'(SPACE_MARK));

   // Wrap for any depth
   function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
      return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge gpif_clk) begin
      if (push) begin
         data_mem[wr_ptr] <= s_tdata;
         last_mem[wr_ptr] <= s_tlast;
      end
   end

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         // Push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* src/gpif_read_path.sv */
`timescale 1ns/1ps

// Flag resampling, read strobe and eop pipelines, downstream capture
module gpif_read_path (
   input  logic                 gpif_clk,
   input  logic                 gpif_rst,
   input  logic [1:0]           gpif_ctl,
   input  gpif_pkg::gpif_word_t gpif_d_in,
   gpif_rd_if.path              rd,
   input  logic                 dn_nearly_full,
   output gpif_pkg::gpif_word_t dn_tdata,
   output logic                 dn_tlast,
   output logic                 dn_tvalid
);

   // First flag stage, meant to sit in the I/O pad
   logic       ready_q;
   logic       wmark_q;
   // Bit n holds slrd delayed by n cycles
   logic [5:1] slrd_pipe;
   logic [2:1] eop_pipe;

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         ready_q        <= 1'b0;
         wmark_q        <= 1'b0;
         rd.fx3_ready   <= 1'b0;
         rd.fx3_wmark   <= 1'b0;
         rd.nearly_full <= 1'b0;
         slrd_pipe      <= '1;
         eop_pipe       <= '0;
      end else begin
         ready_q        <= gpif_ctl[0];
         wmark_q        <= gpif_ctl[1];
         rd.fx3_ready   <= ready_q;
         rd.fx3_wmark   <= wmark_q;
         rd.nearly_full <= dn_nearly_full;
         slrd_pipe      <= {slrd_pipe[4:1], rd.slrd};
         eop_pipe       <= {eop_pipe[1], rd.rx_eop};
      end
   end

   // Capture only useful beats, single reads hold here until tlast is known
   always_ff @(posedge gpif_clk) begin
      if (!slrd_pipe[2]) begin
         dn_tdata <= gpif_d_in;
      end
   end

   assign rd.slrd3     = slrd_pipe[3];
   assign rd.slrd3_low = !slrd_pipe[3];

   // Burst taps stage 3, single beat taps stage 5
   assign dn_tvalid = (rd.burst_active && !slrd_pipe[3]) ||
                      (rd.single_active && !slrd_pipe[5]);

   // Burst end known from the watermark, single end only once ready drops
   assign dn_tlast = (rd.burst_active && eop_pipe[2]) ||
                     (rd.single_active && !rd.fx3_ready);

endmodule

/* src/gpif_endpoint_sel.sv */
`timescale 1ns/1ps

// Endpoint alternation and local readiness per endpoint
module gpif_endpoint_sel (
   input  logic   gpif_clk,
   input  logic   gpif_rst,
   gpif_ep_if.sel ep,
   input  logic   dn_has_space,
   input  logic   up_tvalid
);
   import gpif_pkg::*;

   logic at_tx;
   logic at_rx;

   assign at_tx = (ep.fifoadr == ADDR_DATA_TX);
   assign at_rx = (ep.fifoadr == ADDR_DATA_RX);

   // Addressed endpoint can proceed on the FPGA side
   assign ep.local_ready = (at_tx && dn_has_space) || (at_rx && up_tvalid);

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         ep.next_addr <= ADDR_DATA_TX;
         ep.read_go   <= 1'b0;
         ep.write_go  <= 1'b0;
      end else begin
         // Toggle between the two data endpoints on every load
         if (ep.addr_advance) begin
            ep.next_addr <= (ep.next_addr == ADDR_DATA_TX) ? ADDR_DATA_RX : ADDR_DATA_TX;
         end
         // Room for a packet downstream
         ep.read_go  <= at_tx && dn_has_space;
         // Words waiting upstream
         ep.write_go <= at_rx && up_tvalid;
      end
   end

endmodule

/* src/gpif_master_ctrl.sv */
`timescale 1ns/1ps

// GPIF bus master FSM, owns the strobes, fifoadr and the output data register
module gpif_master_ctrl (
   input  logic                 gpif_clk,
   input  logic                 gpif_rst,
   input  logic                 gpif_enb,
   gpif_rd_if.ctrl              rd,
   gpif_ep_if.ctrl              ep,
   input  gpif_pkg::gpif_word_t up_tdata,
   input  logic                 up_tlast,
   input  logic                 up_tvalid,
   output logic                 up_tready,
   output gpif_pkg::gpif_word_t gpif_d_out,
   output logic                 sloe,
   output logic                 slwr,
   output logic                 pktend
);
   import gpif_pkg::*;

   gpif_state_t state;
   gpif_count_t idle_cycles;
   // Burst start marker, held until stage 3 of slrd goes low
   logic        first_read;
   logic        up_xfer;

   assign rd.burst_active  = (state == ST_READ) || (state == ST_READ_FLUSH);
   assign rd.single_active = (state == ST_READ_SINGLE);

   // Move on in idle, and in wait while this endpoint cannot proceed locally
   assign ep.addr_advance = gpif_enb &&
                            ((state == ST_IDLE) || ((state == ST_WAIT) && !ep.local_ready));

   // Upstream pop, first beat in think, then sustained by the watermark
   assign up_tready = gpif_enb && (ep.fifoadr == ADDR_DATA_RX) &&
                      (((state == ST_THINK) && rd.fx3_ready && ep.write_go) ||
                       ((state == ST_WRITE) && rd.fx3_wmark));
   assign up_xfer = up_tvalid && up_tready;

   // Output data register follows every popped word
   always_ff @(posedge gpif_clk) begin
      if (up_xfer) begin
         gpif_d_out <= up_tdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus master FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         state       <= ST_IDLE;
         idle_cycles <= '0;
         first_read  <= 1'b0;
         rd.rx_eop   <= 1'b0;
         rd.slrd     <= 1'b1;
         slwr        <= 1'b1;
         pktend      <= 1'b1;
         sloe        <= 1'b1;
         ep.fifoadr  <= ADDR_DATA_TX;
      end else if (gpif_enb) begin
         if (ep.addr_advance) begin
            ep.fifoadr <= ep.next_addr;
         end
         case (state)
            // All strobes parked, FPGA owns the bus
            ST_IDLE: begin
               rd.slrd     <= 1'b1;
               slwr        <= 1'b1;
               pktend      <= 1'b1;
               sloe        <= 1'b1;
               rd.rx_eop   <= 1'b0;
               first_read  <= 1'b0;
               idle_cycles <= '0;
               state       <= ST_WAIT;
            end

            // Eight ready cycles let the address reach FX3 and the flags come back
            ST_WAIT: begin
               if (ep.local_ready) begin
                  idle_cycles <= idle_cycles + 1'b1;
                  if (idle_cycles == SETTLE_COUNT) begin
                     state <= ST_THINK;
                  end
               end else begin
                  idle_cycles <= '0;
               end
            end

            // Flags settled, pick a transaction; read_go and write_go never overlap
            ST_THINK: begin
               idle_cycles <= '0;
               if (rd.fx3_ready && rd.fx3_wmark && ep.read_go) begin
                  state      <= ST_READ;
                  rd.slrd    <= 1'b0;
                  rd.rx_eop  <= 1'b0;
                  first_read <= 1'b1;
                  sloe       <= 1'b0;
               end else if (rd.fx3_ready && ep.read_go) begin
                  // Below watermark, one beat at a time
                  state   <= ST_READ_SINGLE;
                  rd.slrd <= 1'b0;
                  sloe    <= 1'b0;
               end else if (rd.fx3_ready && ep.write_go && up_tlast) begin
                  // One-word packet end
                  state       <= ST_WRITE_FLUSH;
                  slwr        <= 1'b0;
                  pktend      <= 1'b0;
                  idle_cycles <= FLUSH_EOP_START;
               end else if (rd.fx3_ready && ep.write_go) begin
                  state <= ST_WRITE;
                  slwr  <= 1'b0;
               end else begin
                  state <= ST_IDLE;
               end
            end

            // Pulse slrd once, then recheck ready after the pipeline has drained
            ST_READ_SINGLE: begin
               if (idle_cycles == '0) begin
                  rd.slrd     <= 1'b1;
                  idle_cycles <= idle_cycles + 1'b1;
               end else if (idle_cycles == SINGLE_RECHECK) begin
                  if (!rd.fx3_ready) begin
                     state <= ST_IDLE;
                     sloe  <= 1'b1;
                  end else begin
                     rd.slrd <= 1'b0;
                  end
                  idle_cycles <= '0;
               end else begin
                  idle_cycles <= idle_cycles + 1'b1;
               end
            end

            // Burst ends on watermark drop (packet end) or a nearly full FIFO
            ST_READ: begin
               if (!rd.fx3_wmark || rd.nearly_full) begin
                  rd.slrd <= 1'b1;
                  state   <= ST_READ_FLUSH;
               end else begin
                  rd.slrd <= 1'b0;
               end
               // Only a true packet end carries tlast
               if (!rd.fx3_wmark) begin
                  rd.rx_eop <= 1'b1;
               end
               if (rd.slrd3_low) begin
                  first_read <= 1'b0;
               end
            end

            // Data still in flight until stage 3 of slrd is high again
            ST_READ_FLUSH: begin
               rd.slrd   <= 1'b1;
               rd.rx_eop <= 1'b0;
               if (rd.slrd3_low) begin
                  first_read <= 1'b0;
               end
               if (!first_read && rd.slrd3) begin
                  state <= ST_IDLE;
                  sloe  <= 1'b1;
               end
            end

            // Write burst, an empty FIFO ends it without pktend
            ST_WRITE: begin
               if (up_xfer && up_tlast) begin
                  state       <= ST_WRITE_FLUSH;
                  slwr        <= 1'b0;
                  pktend      <= 1'b0;
                  idle_cycles <= FLUSH_EOP_START;
               end else if (up_xfer) begin
                  slwr   <= 1'b0;
                  pktend <= 1'b1;
               end else begin
                  state       <= ST_WRITE_FLUSH;
                  slwr        <= 1'b1;
                  pktend      <= 1'b1;
                  idle_cycles <= FLUSH_GAP_START;
               end
            end

            // Hold the address with strobes inactive until the counter wraps
            ST_WRITE_FLUSH: begin
               rd.slrd     <= 1'b1;
               slwr        <= 1'b1;
               pktend      <= 1'b1;
               idle_cycles <= idle_cycles + 1'b1;
               if (idle_cycles == 3'd7) begin
                  state <= ST_IDLE;
               end
            end

            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

/* src/gpif2_to_fifo32.sv */
`timescale 1ns/1ps

// FX3 slave FIFO bus master with one stream per direction
module gpif2_to_fifo32 #(
   parameter int FIFO_DEPTH       = 64,
   parameter int NEARLY_FULL_MARK = 56,
   parameter int SPACE_MARK       = 16
) (
   input  logic                 gpif_clk,
   input  logic                 gpif_rst,
   input  logic                 gpif_enb,
   input  gpif_pkg::gpif_word_t gpif_d_in,
   output gpif_pkg::gpif_word_t gpif_d_out,
   input  logic [1:0]           gpif_ctl,
   output logic                 sloe,
   output logic                 slrd,
   output logic                 slwr,
   output logic                 pktend,
   output gpif_pkg::gpif_addr_t fifoadr,
   // Downstream stream, FX3 to FPGA
   output gpif_pkg::gpif_word_t tx_tdata,
   output logic                 tx_tlast,
   output logic                 tx_tvalid,
   input  logic                 tx_tready,
   // Upstream stream, FPGA to FX3
   input  gpif_pkg::gpif_word_t rx_tdata,
   input  logic                 rx_tlast,
   input  logic                 rx_tvalid,
   output logic                 rx_tready
);
   import gpif_pkg::*;

   // Upstream FIFO output towards the controller
   gpif_word_t up_tdata;
   logic       up_tlast;
   logic       up_tvalid;
   logic       up_tready;

   // Read path output into the downstream FIFO
   gpif_word_t dn_tdata;
   logic       dn_tlast;
   logic       dn_tvalid;
   logic       dn_nearly_full;
   logic       dn_has_space;

   gpif_rd_if rd_bus ();
   gpif_ep_if ep_bus ();

   // Strobe and address pins come off the interfaces
   assign slrd    = rd_bus.slrd;
   assign fifoadr = ep_bus.fifoadr;

   gpif_master_ctrl i_master_ctrl (
      .gpif_clk   (gpif_clk),
      .gpif_rst   (gpif_rst),
      .gpif_enb   (gpif_enb),
      .rd         (rd_bus.ctrl),
      .ep         (ep_bus.ctrl),
      .up_tdata   (up_tdata),
      .up_tlast   (up_tlast),
      .up_tvalid  (up_tvalid),
      .up_tready  (up_tready),
      .gpif_d_out (gpif_d_out),
      .sloe       (sloe),
      .slwr       (slwr),
      .pktend     (pktend)
   );

   gpif_read_path i_read_path (
      .gpif_clk       (gpif_clk),
      .gpif_rst       (gpif_rst),
      .gpif_ctl       (gpif_ctl),
      .gpif_d_in      (gpif_d_in),
      .rd             (rd_bus.path),
      .dn_nearly_full (dn_nearly_full),
      .dn_tdata       (dn_tdata),
      .dn_tlast       (dn_tlast),
      .dn_tvalid      (dn_tvalid)
   );

   gpif_endpoint_sel i_endpoint_sel (
      .gpif_clk     (gpif_clk),
      .gpif_rst     (gpif_rst),
      .ep           (ep_bus.sel),
      .dn_has_space (dn_has_space),
      .up_tvalid    (up_tvalid)
   );

   // Downstream FIFO, levels steer the read decisions
   gpif_sync_fifo #(
      .FIFO_DEPTH       (FIFO_DEPTH),
      .NEARLY_FULL_MARK (NEARLY_FULL_MARK),
      .SPACE_MARK       (SPACE_MARK)
   ) i_dn_fifo (
      .gpif_clk    (gpif_clk),
      .gpif_rst    (gpif_rst),
      .s_tdata     (dn_tdata),
      .s_tlast     (dn_tlast),
      .s_tvalid    (dn_tvalid),
      .s_tready    (),
      .m_tdata     (tx_tdata),
      .m_tlast     (tx_tlast),
      .m_tvalid    (tx_tvalid),
      .m_tready    (tx_tready),
      .nearly_full (dn_nearly_full),
      .has_space   (dn_has_space)
   );

   // Upstream FIFO, only its valid matters to the selector
   gpif_sync_fifo #(
      .FIFO_DEPTH       (FIFO_DEPTH),
      .NEARLY_FULL_MARK (NEARLY_FULL_MARK),
      .SPACE_MARK       (SPACE_MARK)
   ) i_up_fifo (
      .gpif_clk    (gpif_clk),
      .gpif_rst    (gpif_rst),
      .s_tdata     (rx_tdata),
      .s_tlast     (rx_tlast),
      .s_tvalid    (rx_tvalid),
      .s_tready    (rx_tready),
      .m_tdata     (up_tdata),
      .m_tlast     (up_tlast),
      .m_tvalid    (up_tvalid),
      .m_tready    (up_tready),
      .nearly_full (),
      .has_space   ()
   );

endmodule

/* dv/gpif_checker.sv */
`timescale 1ns/1ps

// Watches both streams and the GPIF write side against the packet lists
module gpif_checker #(
   parameter int MAX_WORDS = 64
) (
   input  logic                 gpif_clk,
   input  logic                 gpif_rst,
   input  logic                 slrd,
   input  logic                 slwr,
   input  logic                 pktend,
   input  logic                 sloe,
   input  gpif_pkg::gpif_addr_t fifoadr,
   input  gpif_pkg::gpif_word_t gpif_d_out,
   input  gpif_pkg::gpif_word_t tx_tdata,
   input  logic                 tx_tlast,
   input  logic                 tx_tvalid,
   input  logic                 tx_tready,
   input  logic [32:0]          dn_exp [MAX_WORDS],
   input  int                   dn_count,
   input  logic [32:0]          up_exp [MAX_WORDS],
   input  int                   up_count,
   output int                   errors,
   output int                   dn_seen,
   output int                   up_seen,
   output logic                 done
);
   import gpif_pkg::*;

   // Reset level on the previous edge
   logic rst_d = 1'b1;

   assign done = (dn_seen >= dn_count) && (up_seen >= up_count);

   // Compare one value and log a mismatch
   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Protocol error in plain words
   task automatic note_failure(input string what);
      $display("Error at t=%0t: %s", $time, what);
      errors++;
   endtask

   always @(posedge gpif_clk) begin
      // All strobes parked in the first cycle out of reset
      if (rst_d && !gpif_rst) begin
         compare_value("slrd", 32'd1, 32'(slrd));
         compare_value("slwr", 32'd1, 32'(slwr));
         compare_value("pktend", 32'd1, 32'(pktend));
         compare_value("sloe", 32'd1, 32'(sloe));
         compare_value("tx_tvalid", 32'd0, 32'(tx_tvalid));
      end
      rst_d <= gpif_rst;
      if (!gpif_rst) begin
         // Downstream words in file order
         if (tx_tvalid && tx_tready) begin
            if (dn_seen >= dn_count) begin
               note_failure("extra word on the downstream stream");
            end else begin
               compare_value("tx_tdata", dn_exp[dn_seen][31:0], tx_tdata);
               compare_value("tx_tlast", 32'(dn_exp[dn_seen][32]), 32'(tx_tlast));
            end
            dn_seen++;
         end
         // Upstream words as FX3 records them
         if (!slwr) begin
            if (up_seen >= up_count) begin
               note_failure("extra word written to FX3");
            end else begin
               compare_value("gpif_d_out", up_exp[up_seen][31:0], gpif_d_out);
               compare_value("pktend", 32'(!up_exp[up_seen][32]), 32'(pktend));
            end
            up_seen++;
         end else if (!pktend) begin
            note_failure("pktend low without a write strobe");
         end
         // Strobes only towards their own endpoint
         if (!slrd && fifoadr != ADDR_DATA_TX) begin
            note_failure("slrd low while the upstream endpoint is addressed");
         end
         if (!slwr && fifoadr != ADDR_DATA_RX) begin
            note_failure("slwr low while the downstream endpoint is addressed");
         end
      end
   end

endmodule

/* dv/tb_gpif2_to_fifo32.sv */
`timescale 1ns/1ps

module tb_gpif2_to_fifo32;
   import gpif_pkg::*;

   localparam int MAX_WORDS    = 64;
   localparam int RESET_CYCLES = 3;
   localparam int RUN_TIMEOUT  = 20000;
   localparam int DRAIN_CYCLES = 60;

   logic       gpif_clk;
   logic       gpif_rst = 1'b1;
   logic       gpif_enb = 1'b0;
   gpif_word_t gpif_d_in = '0;
   gpif_word_t gpif_d_out;
   logic [1:0] gpif_ctl = 2'b00;
   logic       sloe;
   logic       slrd;
   logic       slwr;
   logic       pktend;
   gpif_addr_t fifoadr;
   gpif_word_t tx_tdata;
   logic       tx_tlast;
   logic       tx_tvalid;
   logic       tx_tready = 1'b0;
   gpif_word_t rx_tdata = '0;
   logic       rx_tlast = 1'b0;
   logic       rx_tvalid = 1'b0;
   logic       rx_tready;

   // Packets per direction with the last flag in bit 32
   logic [32:0] dn_exp [MAX_WORDS];
   logic [32:0] up_exp [MAX_WORDS];
   int          dn_count;
   int          up_count;

   // FX3 downstream buffer
   int   dn_req_ptr;
   int   dn_data_ptr;
   int   dn_left;
   logic rd_seen;
   int   up_ptr;

   int   load_errors;
   int   model_errors;
   int   timeouts;
   int   check_errors;
   int   dn_seen;
   int   up_seen;
   logic checks_done;

   gpif2_to_fifo32 #(
      .FIFO_DEPTH       (64),
      .NEARLY_FULL_MARK (56),
      .SPACE_MARK       (16)
   ) i_gpif2_to_fifo32 (
      .gpif_clk   (gpif_clk),
      .gpif_rst   (gpif_rst),
      .gpif_enb   (gpif_enb),
      .gpif_d_in  (gpif_d_in),
      .gpif_d_out (gpif_d_out),
      .gpif_ctl   (gpif_ctl),
      .sloe       (sloe),
      .slrd       (slrd),
      .slwr       (slwr),
      .pktend     (pktend),
      .fifoadr    (fifoadr),
      .tx_tdata   (tx_tdata),
      .tx_tlast   (tx_tlast),
      .tx_tvalid  (tx_tvalid),
      .tx_tready  (tx_tready),
      .rx_tdata   (rx_tdata),
      .rx_tlast   (rx_tlast),
      .rx_tvalid  (rx_tvalid),
      .rx_tready  (rx_tready)
   );

   gpif_checker #(
      .MAX_WORDS (MAX_WORDS)
   ) i_checker (
      .gpif_clk   (gpif_clk),
      .gpif_rst   (gpif_rst),
      .slrd       (slrd),
      .slwr       (slwr),
      .pktend     (pktend),
      .sloe       (sloe),
      .fifoadr    (fifoadr),
      .gpif_d_out (gpif_d_out),
      .tx_tdata   (tx_tdata),
      .tx_tlast   (tx_tlast),
      .tx_tvalid  (tx_tvalid),
      .tx_tready  (tx_tready),
      .dn_exp     (dn_exp),
      .dn_count   (dn_count),
      .up_exp     (up_exp),
      .up_count   (up_count),
      .errors     (check_errors),
      .dn_seen    (dn_seen),
      .up_seen    (up_seen),
      .done       (checks_done)
   );

   // Each line holds a direction letter, a hex word and a last bit
   task automatic read_packets();
      int          fd;
      string       line;
      logic [7:0]  dir;
      logic [31:0] word;
      int          last;
      fd = $fopen("dv/gpif_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file dv/gpif_stimulus.txt");
         load_errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "%c %h %d", dir, word, last) == 3) begin
            if (dir == "D" && dn_count < MAX_WORDS) begin
               dn_exp[dn_count] = {last[0], word};
               dn_count++;
            end else if (dir == "U" && up_count < MAX_WORDS) begin
               up_exp[up_count] = {last[0], word};
               up_count++;
            end
         end
      end
      $fclose(fd);
   endtask

   // Words from first up to and including the next last flag
   function automatic int packet_length(input int first);
      int n;
      n = 0;
      for (int i = first; i < dn_count; i++) begin
         n++;
         if (dn_exp[i][32]) begin
            break;
         end
      end
      return n;
   endfunction

   initial begin
      gpif_clk = 1'b0;
      forever #2 gpif_clk = ~gpif_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // FX3 model
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge gpif_clk) begin
      if (gpif_rst) begin
         gpif_ctl    <= 2'b00;
         rd_seen     <= 1'b0;
         dn_req_ptr  <= 0;
         dn_data_ptr <= 0;
         dn_left     <= 0;
      end else begin
         // Each low slrd takes one word off the current packet
         if (!slrd) begin
            if (fifoadr != ADDR_DATA_TX || dn_left == 0) begin
               $display("FX3 model got a read strobe with no data at t=%0t", $time);
               model_errors++;
            end else begin
               dn_left    <= dn_left - 1;
               dn_req_ptr <= dn_req_ptr + 1;
            end
         end
         // Word goes on the bus two cycles after the strobe
         rd_seen <= !slrd && (fifoadr == ADDR_DATA_TX);
         if (rd_seen && dn_data_ptr < dn_count) begin
            gpif_d_in   <= dn_exp[dn_data_ptr][31:0];
            dn_data_ptr <= dn_data_ptr + 1;
         end
         // Next packet only loads while the other endpoint is addressed
         if (fifoadr == ADDR_DATA_RX && dn_left == 0 && dn_req_ptr < dn_count) begin
            dn_left <= packet_length(dn_req_ptr);
         end
         // Flags lag the count by one cycle as on the real part
         if (fifoadr == ADDR_DATA_RX) begin
            gpif_ctl <= 2'b11;
         end else begin
            gpif_ctl <= {dn_left > 4, dn_left > 0};
         end
      end
   end

   // Stream drivers with random stalls and gaps
   always @(posedge gpif_clk) begin
      int next_up;
      if (gpif_rst) begin
         tx_tready <= 1'b0;
         rx_tvalid <= 1'b0;
         up_ptr    <= 0;
      end else begin
         tx_tready <= ($urandom % 4) != 0;
         next_up = up_ptr;
         if (rx_tvalid && rx_tready) begin
            next_up++;
         end
         up_ptr <= next_up;
         if (next_up < up_count && ($urandom % 5) != 0) begin
            rx_tvalid <= 1'b1;
            rx_tdata  <= up_exp[next_up][31:0];
            rx_tlast  <= up_exp[next_up][32];
         end else begin
            rx_tvalid <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int cycles;
      void'($urandom(65));
      read_packets();
      repeat (RESET_CYCLES) @(posedge gpif_clk);
      gpif_rst <= 1'b0;
      gpif_enb <= 1'b1;
      cycles = 0;
      while (!checks_done && cycles < RUN_TIMEOUT) begin
         @(posedge gpif_clk);
         cycles++;
      end
      if (!checks_done) begin
         $display("Timeout after %0d cycles, streams still incomplete", RUN_TIMEOUT);
         timeouts++;
      end
      // Let any stray or duplicate word show up
      cycles = 0;
      while (cycles < DRAIN_CYCLES) begin
         @(posedge gpif_clk);
         cycles++;
      end
      $display("Errors %0d model %0d load %0d timeouts %0d down %0d/%0d up %0d/%0d",
               check_errors, model_errors, load_errors, timeouts,
               dn_seen, dn_count, up_seen, up_count);
      if (check_errors == 0 && model_errors == 0 && load_errors == 0 && timeouts == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* dv/gpif_stimulus.txt */
# Columns: direction (D downstream, U upstream), 32-bit hex word, last bit
# D packets over 4 words use bursts, shorter ones single reads
D a0000001 0
D a0000002 0
D a0000003 0
D a0000004 0
D a0000005 0
D a0000006 0
D a0000007 1
U c0000001 0
U c0000002 0
U c0000003 0
U c0000004 0
U c0000005 1
D b1000001 0
D b1000002 0
D b1000003 1
U c1000001 1
D b2000001 1
U c2000001 0
U c2000002 0
U c2000003 1

/* gpif2_to_fifo32.f */
src/gpif_pkg.sv
src/gpif_rd_if.sv
src/gpif_ep_if.sv
src/gpif_sync_fifo.sv
src/gpif_read_path.sv
src/gpif_endpoint_sel.sv
src/gpif_master_ctrl.sv
src/gpif2_to_fifo32.sv
dv/gpif_checker.sv
dv/tb_gpif2_to_fifo32.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f gpif2_to_fifo32.f --top-module tb_gpif2_to_fifo32 -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
